//--- verilog.f
logic/fifo_pkg.sv
logic/cdc_sync.sv
logic/gray_ptr_counter.sv
logic/fifo_mem.sv
logic/fifo_write_ctrl.sv
logic/fifo_read_ctrl.sv
logic/async_fifo_top.sv
sim/async_fifo_tb.sv

//--- sim/async_fifo_tb.sv
// async_fifo_tb: two drifting clocks, reset, directed and random traffic
// reference queue model and concurrent checks on data and flags

module async_fifo_tb;

	import fifo_pkg::*;

	// run limit in write_clk cycles
	localparam int TIMEOUT_CYCLES = 4000;
	// random phase length per domain, read side scaled by 20/26
	localparam int RANDOM_CYCLES = 1500;
	localparam int READ_CYCLES = 1153;
	// flag lag allowed, two sync flops plus the full register
	localparam int SETTLE_EDGES = 3;

	logic write_clk;
	logic read_clk;
	logic reset_rsync;
	logic write_en;
	logic read_en;
	fifo_data_t write_data;
	logic full;
	logic empty;
	fifo_data_t read_data;

	// reference model state
	fifo_data_t ref_queue[$];
	int pushed_count;
	int popped_count;
	int queue_level;
	fifo_data_t expected_word;
	logic data_check;
	int stale_full;
	int full_wait;
	int stale_empty;

	logic checks_armed;
	int cycle_count;
	int seed;
	int read_seed;
	int data_errors;
	int flag_errors;
	int level_errors;

	async_fifo_top UUT
	(
		.write_clk(write_clk),
		.read_clk(read_clk),
		.reset_rsync(reset_rsync),
		.write_en(write_en),
		.read_en(read_en),
		.write_data(write_data),
		.full(full),
		.empty(empty),
		.read_data(read_data)
	);

	initial
	begin
		write_clk = 1'b0;
		forever #10 write_clk = ~write_clk;
	end

	// 26 against 20, so edges drift and line up every 260
	initial
	begin
		read_clk = 1'b0;
		forever #13 read_clk = ~read_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// counts move on NBAs, so every block sees the level from before the edge
	always_comb
		queue_level = pushed_count - popped_count;

	always @(posedge write_clk)
	begin
		if (write_en && full === 1'b0)
		begin
			ref_queue.push_back(write_data);
			pushed_count <= pushed_count + 1;
		end
		// full still high although a read freed an entry
		if (full === 1'b1 && queue_level < FIFO_DEPTH)
			stale_full <= stale_full + 1;
		else
			stale_full <= 0;
		// eight words held but full not yet up
		if (full === 1'b0 && queue_level == FIFO_DEPTH)
			full_wait <= full_wait + 1;
		else
			full_wait <= 0;
	end

	// popped word is due on read_data at the next read_clk edge
	// and read_data must hold it until the next pop
	always @(posedge read_clk)
	begin
		if (read_en && empty === 1'b0 && ref_queue.size() > 0)
		begin
			expected_word <= ref_queue.pop_front();
			popped_count <= popped_count + 1;
			data_check <= 1'b1;
		end
		if (empty === 1'b1 && queue_level > 0)
			stale_empty <= stale_empty + 1;
		else
			stale_empty <= 0;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	read_data_ok: assert property (@(posedge read_clk) disable iff (!checks_armed)
		data_check |-> (read_data == expected_word))
	else
	begin
		data_errors++;
		$display("** Error: %0t: read_data %h, expected %h", $time,
			$sampled(read_data), $sampled(expected_word));
	end

	// empty low means data really is there
	no_underflow: assert property (@(posedge read_clk) disable iff (!checks_armed)
		!empty |-> (queue_level > 0))
	else
	begin
		flag_errors++;
		$display("** Error: %0t: empty is low with no word in the reference queue", $time);
	end

	empty_settles: assert property (@(posedge read_clk) disable iff (!checks_armed)
		stale_empty <= SETTLE_EDGES)
	else
	begin
		flag_errors++;
		$display("** Error: %0t: empty stayed high for %0d edges with data queued",
			$time, $sampled(stale_empty));
	end

	no_overflow: assert property (@(posedge write_clk) disable iff (!checks_armed)
		queue_level <= FIFO_DEPTH)
	else
	begin
		level_errors++;
		$display("write accepted while full, the FIFO now holds %0d words",
			$sampled(queue_level));
	end

	full_rises: assert property (@(posedge write_clk) disable iff (!checks_armed)
		full_wait <= 3)
	else
	begin
		flag_errors++;
		$display("** Error: %0t: full still low 3 cycles after the FIFO filled", $time);
	end

	full_settles: assert property (@(posedge write_clk) disable iff (!checks_armed)
		stale_full <= SETTLE_EDGES)
	else
	begin
		flag_errors++;
		$display("** Error: %0t: full stayed high for %0d cycles with a free entry",
			$time, $sampled(stale_full));
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	// back-to-back writes of base, base+1, ..., then write_en drops
	task drive_writes(input int count, input fifo_data_t base);
		int k;
		for (k = 0; k < count; k++)
		begin
			@(posedge write_clk);
			write_en <= 1'b1;
			write_data <= base + fifo_data_t'(k);
		end
		@(posedge write_clk);
		write_en <= 1'b0;
	endtask

	// read until the reference queue is empty, one more edge for the last check
	task drain_fifo;
		@(posedge read_clk);
		read_en <= 1'b1;
		do
			@(negedge read_clk);
		while (queue_level != 0);
		@(posedge read_clk);
		read_en <= 1'b0;
		@(posedge read_clk);
	endtask

	// writes heavy in the first half, reads heavy in the second
	task random_writes;
		int i;
		for (i = 0; i < RANDOM_CYCLES; i++)
		begin
			@(posedge write_clk);
			if (i < RANDOM_CYCLES / 2)
				write_en <= (($random(seed) & 3) != 0);
			else
				write_en <= (($random(seed) & 3) == 0);
			write_data <= $random(seed);
		end
		@(posedge write_clk);
		write_en <= 1'b0;
	endtask

	task random_reads;
		int j;
		for (j = 0; j < READ_CYCLES; j++)
		begin
			@(posedge read_clk);
			if (j < READ_CYCLES / 2)
				read_en <= (($random(read_seed) & 3) == 0);
			else
				read_en <= (($random(read_seed) & 3) != 0);
		end
		@(posedge read_clk);
		read_en <= 1'b0;
	endtask

	initial
	begin
		reset_rsync = 1'b1;
		write_en = 1'b0;
		read_en = 1'b0;
		write_data = '0;
		pushed_count = 0;
		popped_count = 0;
		expected_word = '0;
		data_check = 1'b0;
		stale_full = 0;
		full_wait = 0;
		stale_empty = 0;
		checks_armed = 1'b0;
		data_errors = 0;
		flag_errors = 0;
		level_errors = 0;
		seed = 32'h3722e405;
		// reader gets its own stream so coincident edges stay order free
		read_seed = $random(seed);

		repeat (5) @(posedge write_clk);
		reset_rsync <= 1'b0;

		// idle flags after reset
		repeat (3) @(posedge write_clk);
		repeat (3) @(posedge read_clk);
		@(negedge write_clk);
		reset_flags: assert (empty === 1'b1 && full === 1'b0)
		else
		begin
			flag_errors++;
			$display("** Error: %0t: after reset empty %b full %b, expected 1 and 0",
				$time, empty, full);
		end
		checks_armed = 1'b1;

		// short burst through and back out
		drive_writes(5, 32'h1000_0000);
		drain_fifo();

		// one past capacity, the last word must be dropped
		drive_writes(FIFO_DEPTH + 1, 32'h2000_0000);
		repeat (3) @(posedge write_clk);
		drain_fifo();

		// read_en held on an empty FIFO, then words arrive under it
		@(posedge read_clk);
		read_en <= 1'b1;
		repeat (8) @(posedge read_clk);
		drive_writes(3, 32'h3000_0000);
		drain_fifo();

		fork
			random_writes();
			random_reads();
		join
		drain_fifo();

		$display("errors: data %0d, flag %0d, level %0d", data_errors, flag_errors,
			level_errors);
		if (data_errors + flag_errors + level_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// run limit
	initial
		cycle_count = 0;

	always @(posedge write_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d write_clk cycles",
				TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

endmodule

//--- logic/async_fifo_top.sv
// async_fifo_top: dual-clock FIFO top level
// reset bridge into read_clk, write side, read side and storage

module async_fifo_top
(
	input logic write_clk,
	input logic read_clk,
	input logic reset_rsync,
	input logic write_en,
	input logic read_en,
	input fifo_pkg::fifo_data_t write_data,
	output logic full,
	output logic empty,
	output fifo_pkg::fifo_data_t read_data
);

	import fifo_pkg::*;

	// write reset as seen in the read domain
	logic reset_read;
	// gray pointers crossing between domains
	fifo_ptr_t wr_gray;
	fifo_ptr_t rd_gray;
	// storage addresses and strobes
	fifo_addr_t wr_addr;
	fifo_addr_t rd_addr;
	logic write_strobe;
	logic read_strobe;

	// reset bridge, two read_clk flops
	cdc_sync #(.WIDTH(1)) u_reset_sync
	(
		.clk(read_clk),
		.d(reset_rsync),
		.q(reset_read)
	);

	fifo_write_ctrl u_write_ctrl
	(
		.write_clk(write_clk),
		.reset_rsync(reset_rsync),
		.write_en(write_en),
		.rd_gray(rd_gray),
		.wr_gray(wr_gray),
		.wr_addr(wr_addr),
		.write_strobe(write_strobe),
		.full(full)
	);

	fifo_read_ctrl u_read_ctrl
	(
		.read_clk(read_clk),
		.reset_read(reset_read),
		.read_en(read_en),
		.wr_gray(wr_gray),
		.rd_gray(rd_gray),
		.rd_addr(rd_addr),
		.read_strobe(read_strobe),
		.empty(empty)
	);

	fifo_mem u_mem
	(
		.write_clk(write_clk),
		.write_strobe(write_strobe),
		.write_addr(wr_addr),
		.write_data(write_data),
		.read_clk(read_clk),
		.read_strobe(read_strobe),
		.read_addr(rd_addr),
		.read_data(read_data)
	);

endmodule

//--- logic/fifo_read_ctrl.sv
// fifo_read_ctrl: read pointer, write pointer synchronizer
// and the empty flag

module fifo_read_ctrl
(
	input logic read_clk,
	input logic reset_read,
	input logic read_en,
	input fifo_pkg::fifo_ptr_t wr_gray,
	output fifo_pkg::fifo_ptr_t rd_gray,
	output fifo_pkg::fifo_addr_t rd_addr,
	output logic read_strobe,
	output logic empty
);

	import fifo_pkg::*;

	// read pointer, binary and gray
	ptr_pair_t rd_ptr;
	// write gray pointer after two read_clk flops
	fifo_ptr_t wr_gray_sync;

	////////////////////////////////////////////////////////////////////////////
	// crossing and flag
	////////////////////////////////////////////////////////////////////////////

	// write pointer crosses into the read domain
	cdc_sync #(.WIDTH(PTR_WIDTH)) u_wr_sync
	(
		.clk(read_clk),
		.d(wr_gray),
		.q(wr_gray_sync)
	);

	// equal pointers, wrap bit included, mean nothing to read
	// a late write pointer only keeps empty high longer
	assign empty = (wr_gray_sync == rd_ptr.gray);

	////////////////////////////////////////////////////////////////////////////
	// pointer
	////////////////////////////////////////////////////////////////////////////

	// a read while empty is ignored
	// strobe also loads read_data in storage
	assign read_strobe = read_en && !empty;

	gray_ptr_counter u_rd_ptr
	(
		.clk(read_clk),
		.reset(reset_read),
		.advance(read_strobe),
		.ptr(rd_ptr)
	);

	// head entry address, before the advance
	assign rd_addr = rd_ptr.bin.field.addr;

	// exported for the write side full check
	assign rd_gray = rd_ptr.gray;

endmodule

//--- logic/fifo_write_ctrl.sv
// fifo_write_ctrl: write pointer, read pointer synchronizer
// and the registered full flag

module fifo_write_ctrl
(
	input logic write_clk,
	input logic reset_rsync,
	input logic write_en,
	input fifo_pkg::fifo_ptr_t rd_gray,
	output fifo_pkg::fifo_ptr_t wr_gray,
	output fifo_pkg::fifo_addr_t wr_addr,
	output logic write_strobe,
	output logic full
);

	import fifo_pkg::*;

	// write pointer, binary and gray
	ptr_pair_t wr_ptr;
	// read gray pointer after two write_clk flops
	fifo_ptr_t rd_gray_sync;
	// binary pointer as it stands after this cycle's write
	fifo_ptr_u wr_bin_after;
	// its gray code
	fifo_ptr_t wr_gray_after;
	// xor of write and read gray pointers, viewed as wrap/address
	fifo_ptr_u full_check;
	// full as it will be after this edge
	logic full_next;

	// a write while full is dropped
	assign write_strobe = write_en && !full;

	gray_ptr_counter u_wr_ptr
	(
		.clk(write_clk),
		.reset(reset_rsync),
		.advance(write_strobe),
		.ptr(wr_ptr)
	);

	// read pointer crosses into the write domain
	cdc_sync #(.WIDTH(PTR_WIDTH)) u_rd_sync
	(
		.clk(write_clk),
		.d(rd_gray),
		.q(rd_gray_sync)
	);

	assign wr_gray = wr_ptr.gray;
	assign wr_addr = wr_ptr.bin.field.addr;

	////////////////////////////////////////////////////////////////////////////
	// full look-ahead
	////////////////////////////////////////////////////////////////////////////

	// full in gray means the top two bits differ and the rest match
	// compared against the pointer after a write in this cycle
	// so full rises on the edge of the write that fills the FIFO
	always_comb
	begin
		wr_bin_after.count = wr_ptr.bin.count + fifo_ptr_t'(write_strobe);
		wr_gray_after = wr_bin_after.count ^ (wr_bin_after.count >> 1);
		full_check.count = wr_gray_after ^ rd_gray_sync;
		full_next = full_check.field.wrap
			&& full_check.field.addr[ADDR_WIDTH-1]
			&& (full_check.field.addr[ADDR_WIDTH-2:0] == '0);
	end

	// stale read pointer only keeps full high longer
	always_ff @(posedge write_clk)
	begin
		if (reset_rsync)
			full <= 1'b0;
		else
			full <= full_next;
	end

endmodule

//--- logic/fifo_mem.sv
// fifo_mem: FIFO storage array
// write port on write_clk, registered read port on read_clk

module fifo_mem
(
	input logic write_clk,
	input logic write_strobe,
	input fifo_pkg::fifo_addr_t write_addr,
	input fifo_pkg::fifo_data_t write_data,
	input logic read_clk,
	input logic read_strobe,
	input fifo_pkg::fifo_addr_t read_addr,
	output fifo_pkg::fifo_data_t read_data
);

	import fifo_pkg::*;

	// storage, FIFO_DEPTH words
	fifo_data_t mem [FIFO_DEPTH];

	// write side
	// word lands at the write address on the accepting edge
	always_ff @(posedge write_clk)
	begin
		if (write_strobe)
			mem[write_addr] <= write_data;
	end

	// read side
	// head entry loads on the accepting edge, holds otherwise
	always_ff @(posedge read_clk)
	begin
		if (read_strobe)
			read_data <= mem[read_addr];
	end

endmodule

//--- logic/gray_ptr_counter.sv
// gray_ptr_counter: binary FIFO pointer and its gray code
// both step together on the edge after advance

module gray_ptr_counter
(
	input logic clk,
	input logic reset,
	input logic advance,
	output fifo_pkg::ptr_pair_t ptr
);

	import fifo_pkg::*;

	// next binary value
	fifo_ptr_u bin_next;
	// gray code of the next binary value
	fifo_ptr_t gray_next;

	// increment wraps at 2*FIFO_DEPTH through the extra bit
	// gray = bin ^ (bin >> 1), one bit changes per step
	always_comb
	begin
		bin_next.count = ptr.bin.count + fifo_ptr_t'(1);
		gray_next = bin_next.count ^ (bin_next.count >> 1);
	end

	// both codes load on the same edge
	// so the gray output always matches the binary one
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ptr <= '0;
		end
		else if (advance)
		begin
			ptr.bin <= bin_next;
			ptr.gray <= gray_next;
		end
	end

endmodule

//--- logic/cdc_sync.sv
// cdc_sync: two-flop synchronizer for a bus entering the clk domain

module cdc_sync
#(
	// bus width, 4 for a gray pointer, 1 for the reset bridge
	parameter int WIDTH = 1
)
(
	input logic clk,
	input logic [WIDTH-1:0] d,
	output logic [WIDTH-1:0] q
);

	// first stage, may go metastable
	logic [WIDTH-1:0] meta;

	// two stages, no reset
	// only gray-coded or single-bit values arrive here
	// so at most one bit is in motion at a time
	always_ff @(posedge clk)
	begin
		meta <= d;
		// second stage settles the first
		q <= meta;
	end

endmodule

//--- logic/fifo_pkg.sv
// fifo_pkg: FIFO sizes, data and pointer types
// pointer union (count or wrap/address view) and binary/gray pointer pair

package fifo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////

	// number of entries, power of two and at least 4
	localparam int FIFO_DEPTH = 8;

	// bits to address one entry
	localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

	// one extra wrap bit tells full from empty
	localparam int PTR_WIDTH = ADDR_WIDTH + 1;

	// payload width of one entry
	localparam int DATA_WIDTH = 32;

	////////////////////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [DATA_WIDTH-1:0] fifo_data_t;
	typedef logic [ADDR_WIDTH-1:0] fifo_addr_t;

	// binary pointer or its gray code
	typedef logic [PTR_WIDTH-1:0] fifo_ptr_t;

	// one pointer word, read either as a count or split into wrap and address
	typedef union packed
	{
		// whole count, incremented by the counter
		fifo_ptr_t count;
		// wrap bit on top, entry address below
		struct packed
		{
			logic wrap;
			fifo_addr_t addr;
		} field;
	} fifo_ptr_u;

	// binary pointer travels with its gray code
	typedef struct packed
	{
		fifo_ptr_u bin;
		fifo_ptr_t gray;
	} ptr_pair_t;

endpackage
